// ==== sources.f ====
verilog/mcu_bus_pkg.sv
verilog/mcu_addr_pkg.sv
verilog/wb_bus_if.sv
verilog/system_bus.sv
verilog/memory_subsystem.sv
verilog/ao_peripheral_subsystem.sv
verilog/gpio_peripheral.sv
verilog/core_v_mini_mcu.sv
test/tb_core_v_mini_mcu.sv

// ==== Makefile ====
# Verilator build and run for the mini MCU testbench

VERILATOR ?= verilator
TOP       ?= tb_core_v_mini_mcu
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

test: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/tb_core_v_mini_mcu.sv ====
// Testbench for the mini MCU bus fabric
// random Wishbone traffic against a model of RAM, always-on and GPIO registers
`default_nettype none

module tb_core_v_mini_mcu;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int RESET_CYCLES = 16;
  localparam int RAM_WRITES = 200;
  localparam int XFER_WAIT_LIMIT = 4;
  // transfer budget at 4 cycles each plus margin
  localparam int XFER_BUDGET = 400;
  localparam int CYCLES_PER_XFER = 4;
  localparam int TIMEOUT_CYCLES = XFER_BUDGET * CYCLES_PER_XFER + 2400;

  logic clk_i;
  logic reset_i;
  logic wb_cyc_i;
  logic wb_stb_i;
  logic wb_we_i;
  mcu_bus_pkg::addr_t wb_adr_i;
  mcu_bus_pkg::data_t wb_dat_i;
  mcu_bus_pkg::sel_t wb_sel_i;
  mcu_bus_pkg::data_t wb_dat_o;
  logic wb_ack_o;
  logic wb_err_o;
  logic boot_select_i;
  mcu_bus_pkg::data_t exit_value_o;
  logic exit_valid_o;
  mcu_bus_pkg::data_t gpio_i;
  mcu_bus_pkg::data_t gpio_o;
  mcu_bus_pkg::data_t gpio_en_o;

  int seed;
  int cycle_count;

  // reference model state
  mcu_bus_pkg::data_t ram_model [mcu_bus_pkg::addr_t];
  mcu_bus_pkg::addr_t ram_written [$];
  mcu_bus_pkg::data_t scratch_model;
  mcu_bus_pkg::data_t exit_model;
  mcu_bus_pkg::data_t gpio_out_model;
  mcu_bus_pkg::data_t gpio_en_model;

  core_v_mini_mcu dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      stop_on_failure();
    end
  end

  task automatic stop_on_failure;
    $display("=== FAIL ===");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
      stop_on_failure();
    end
  endtask

  // byte lanes under sel take the new word
  function automatic mcu_bus_pkg::data_t masked_update(mcu_bus_pkg::data_t old_word,
                                                       mcu_bus_pkg::data_t new_word,
                                                       mcu_bus_pkg::sel_t sel);
    mcu_bus_pkg::data_t mask;
    mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  function automatic mcu_bus_pkg::addr_t reg_addr(mcu_addr_pkg::region_t region,
                                                  mcu_addr_pkg::reg_off_t off);
    return {region, 24'h0, off, 2'b00};
  endfunction

  // one classic transfer, entered and left on a falling edge
  task automatic bus_xfer(input logic we, input mcu_bus_pkg::addr_t adr,
                          input mcu_bus_pkg::data_t wdata, input mcu_bus_pkg::sel_t sel,
                          input logic expect_err, output mcu_bus_pkg::data_t rdata);
    int waited;
    // previous response must be gone before a new request
    check_value("wb_ack_o", 32'(wb_ack_o), 32'(0));
    check_value("wb_err_o", 32'(wb_err_o), 32'(0));
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i = we;
    wb_adr_i = adr;
    wb_dat_i = wdata;
    wb_sel_i = sel;
    waited = 0;
    do begin
      @(negedge clk_i);
      waited++;
    end while (!(wb_ack_o || wb_err_o) && waited < XFER_WAIT_LIMIT);
    assert (wb_ack_o || wb_err_o) else begin
      $display("No response to the transfer at address %h", adr);
      stop_on_failure();
    end
    assert (waited == 1) else begin
      $display("Response to address %h came %0d cycles after the request", adr, waited);
      stop_on_failure();
    end
    check_value("wb_err_o", 32'(wb_err_o), 32'(expect_err));
    check_value("wb_ack_o", 32'(wb_ack_o), 32'(!expect_err));
    rdata = wb_dat_o;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i = 1'b0;
    @(negedge clk_i);
  endtask

  task automatic write_reg(input mcu_bus_pkg::addr_t adr, input mcu_bus_pkg::data_t d,
                           input mcu_bus_pkg::sel_t s);
    mcu_bus_pkg::data_t unused;
    bus_xfer(1'b1, adr, d, s, 1'b0, unused);
  endtask

  task automatic read_expect(input mcu_bus_pkg::addr_t adr, input mcu_bus_pkg::data_t exp);
    mcu_bus_pkg::data_t rd;
    bus_xfer(1'b0, adr, '0, 4'hf, 1'b0, rd);
    check_value($sformatf("wb_dat_o at %h", adr), rd, exp);
  endtask

  task automatic check_registers;
    read_expect(reg_addr(mcu_addr_pkg::REGION_AO, mcu_addr_pkg::AO_SCRATCH), scratch_model);
    read_expect(reg_addr(mcu_addr_pkg::REGION_AO, mcu_addr_pkg::AO_EXIT), exit_model);
    read_expect(reg_addr(mcu_addr_pkg::REGION_PERIPH, mcu_addr_pkg::GPIO_OUT), gpio_out_model);
    read_expect(reg_addr(mcu_addr_pkg::REGION_PERIPH, mcu_addr_pkg::GPIO_EN), gpio_en_model);
  endtask

  task automatic ram_random_traffic;
    int writes;
    int idx;
    mcu_bus_pkg::addr_t adr;
    mcu_bus_pkg::data_t d;
    mcu_bus_pkg::sel_t s;
    writes = 0;
    while (writes < RAM_WRITES) begin
      if (ram_written.size() > 0 && ($random(seed) & 1)) begin
        idx = int'({$random(seed)} % ram_written.size());
        read_expect(ram_written[idx], ram_model[ram_written[idx]]);
      end else begin
        adr = mcu_bus_pkg::addr_t'({$random(seed)} % mcu_addr_pkg::RAM_BYTES);
        adr[1:0] = 2'b00;
        d = mcu_bus_pkg::data_t'($random(seed));
        s = mcu_bus_pkg::sel_t'($random(seed));
        // first write to a word fills all bytes so later reads are known
        if (ram_model.exists(adr)) begin
          ram_model[adr] = masked_update(ram_model[adr], d, s);
        end else begin
          s = 4'hf;
          ram_model[adr] = d;
          ram_written.push_back(adr);
        end
        write_reg(adr, d, s);
        writes++;
      end
    end
  endtask

  task automatic ao_register_access;
    mcu_bus_pkg::data_t d;
    mcu_bus_pkg::sel_t s;
    d = mcu_bus_pkg::data_t'($random(seed));
    s = mcu_bus_pkg::sel_t'($random(seed));
    scratch_model = masked_update(scratch_model, d, s);
    write_reg(reg_addr(mcu_addr_pkg::REGION_AO, mcu_addr_pkg::AO_SCRATCH), d, s);
    read_expect(reg_addr(mcu_addr_pkg::REGION_AO, mcu_addr_pkg::AO_SCRATCH), scratch_model);
    for (int b = 1; b >= 0; b--) begin
      boot_select_i = b[0];
      read_expect(reg_addr(mcu_addr_pkg::REGION_AO, mcu_addr_pkg::AO_BOOT_SEL), 32'(b));
      write_reg(reg_addr(mcu_addr_pkg::REGION_AO, mcu_addr_pkg::AO_BOOT_SEL),
                mcu_bus_pkg::data_t'($random(seed)), 4'hf);
      read_expect(reg_addr(mcu_addr_pkg::REGION_AO, mcu_addr_pkg::AO_BOOT_SEL), 32'(b));
    end
    check_value("exit_valid_o", 32'(exit_valid_o), 32'(0));
    exit_model = mcu_bus_pkg::data_t'($random(seed));
    write_reg(reg_addr(mcu_addr_pkg::REGION_AO, mcu_addr_pkg::AO_EXIT), exit_model, 4'hf);
    check_value("exit_value_o", exit_value_o, exit_model);
    check_value("exit_valid_o", 32'(exit_valid_o), 32'(1));
    check_registers();
  endtask

  task automatic gpio_register_access;
    mcu_bus_pkg::data_t d;
    mcu_bus_pkg::sel_t s;
    for (int i = 0; i < 8; i++) begin
      d = mcu_bus_pkg::data_t'($random(seed));
      s = mcu_bus_pkg::sel_t'($random(seed));
      gpio_out_model = masked_update(gpio_out_model, d, s);
      write_reg(reg_addr(mcu_addr_pkg::REGION_PERIPH, mcu_addr_pkg::GPIO_OUT), d, s);
      check_value("gpio_o", gpio_o, gpio_out_model);
      d = mcu_bus_pkg::data_t'($random(seed));
      s = mcu_bus_pkg::sel_t'($random(seed));
      gpio_en_model = masked_update(gpio_en_model, d, s);
      write_reg(reg_addr(mcu_addr_pkg::REGION_PERIPH, mcu_addr_pkg::GPIO_EN), d, s);
      check_value("gpio_en_o", gpio_en_o, gpio_en_model);
      // pin value crosses the two-flop synchronizer
      gpio_i = mcu_bus_pkg::data_t'($random(seed));
      repeat (3) @(negedge clk_i);
      read_expect(reg_addr(mcu_addr_pkg::REGION_PERIPH, mcu_addr_pkg::GPIO_IN), gpio_i);
    end
    check_registers();
  endtask

  task automatic unmapped_error_access;
    int r;
    mcu_bus_pkg::data_t rnd;
    mcu_bus_pkg::data_t rd;
    mcu_bus_pkg::addr_t adr;
    for (int i = 0; i < 20; i++) begin
      // region 1 or 4 to 15
      r = int'({$random(seed)} % 13);
      rnd = mcu_bus_pkg::data_t'($random(seed));
      adr = {mcu_addr_pkg::region_t'(r == 0 ? 1 : r + 3), rnd[27:2], 2'b00};
      bus_xfer(1'(($random(seed)) & 1), adr, mcu_bus_pkg::data_t'($random(seed)),
               mcu_bus_pkg::sel_t'($random(seed)), 1'b1, rd);
    end
    check_registers();
    foreach (ram_written[i]) begin
      read_expect(ram_written[i], ram_model[ram_written[i]]);
    end
  endtask

  initial begin
    seed = 25691;
    cycle_count = 0;
    reset_i = 1'b1;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    wb_sel_i = '0;
    boot_select_i = 1'b0;
    gpio_i = '0;
    scratch_model = '0;
    exit_model = '0;
    gpio_out_model = '0;
    gpio_en_model = '0;
    repeat (RESET_CYCLES) @(negedge clk_i);
    reset_i = 1'b0;
    @(negedge clk_i);
    check_value("wb_ack_o", 32'(wb_ack_o), 32'(0));
    check_value("wb_err_o", 32'(wb_err_o), 32'(0));
    check_value("exit_valid_o", 32'(exit_valid_o), 32'(0));
    check_value("gpio_o", gpio_o, '0);
    check_value("gpio_en_o", gpio_en_o, '0);
    read_expect(reg_addr(mcu_addr_pkg::REGION_AO, mcu_addr_pkg::AO_SCRATCH), '0);
    ram_random_traffic();
    ao_register_access();
    gpio_register_access();
    unmapped_error_access();
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/core_v_mini_mcu.sv ====
// Mini MCU top level
// one Wishbone master port into the system bus, RAM, always-on block and GPIO
`default_nettype none

module core_v_mini_mcu (
  input  logic               clk_i,
  input  logic               reset_i,

  input  logic               wb_cyc_i,
  input  logic               wb_stb_i,
  input  logic               wb_we_i,
  input  mcu_bus_pkg::addr_t wb_adr_i,
  input  mcu_bus_pkg::data_t wb_dat_i,
  input  mcu_bus_pkg::sel_t  wb_sel_i,
  output mcu_bus_pkg::data_t wb_dat_o,
  output logic               wb_ack_o,
  output logic               wb_err_o,

  input  logic               boot_select_i,
  output mcu_bus_pkg::data_t exit_value_o,
  output logic               exit_valid_o,

  input  mcu_bus_pkg::data_t gpio_i,
  output mcu_bus_pkg::data_t gpio_o,
  output mcu_bus_pkg::data_t gpio_en_o
);

  wb_bus_if host_bus ();
  wb_bus_if ram_bus ();
  wb_bus_if ao_bus ();
  wb_bus_if periph_bus ();

  // external master port
  assign host_bus.cyc = wb_cyc_i;
  assign host_bus.stb = wb_stb_i;
  assign host_bus.we = wb_we_i;
  assign host_bus.adr = wb_adr_i;
  assign host_bus.dat_w = wb_dat_i;
  assign host_bus.sel = wb_sel_i;
  assign wb_dat_o = host_bus.dat_r;
  assign wb_ack_o = host_bus.ack;
  assign wb_err_o = host_bus.err;

  system_bus system_bus_i (
    .clk_i,
    .reset_i,
    .host    (host_bus.slave),
    .ram_o   (ram_bus.master),
    .ao_o    (ao_bus.master),
    .periph_o(periph_bus.master)
  );

  memory_subsystem memory_subsystem_i (
    .clk_i,
    .reset_i,
    .bus(ram_bus.slave)
  );

  ao_peripheral_subsystem ao_peripheral_subsystem_i (
    .clk_i,
    .reset_i,
    .bus(ao_bus.slave),
    .boot_select_i,
    .exit_value_o,
    .exit_valid_o
  );

  gpio_peripheral gpio_peripheral_i (
    .clk_i,
    .reset_i,
    .bus(periph_bus.slave),
    .gpio_i,
    .gpio_o,
    .gpio_en_o
  );

endmodule

`default_nettype wire

// ==== verilog/gpio_peripheral.sv ====
// GPIO peripheral
// output and enable registers plus a two-flop input synchronizer
`default_nettype none

module gpio_peripheral (
  input  logic               clk_i,
  input  logic               reset_i,
  wb_bus_if.slave            bus,
  input  mcu_bus_pkg::data_t gpio_i,
  output mcu_bus_pkg::data_t gpio_o,
  output mcu_bus_pkg::data_t gpio_en_o
);

  mcu_addr_pkg::reg_off_t offset;
  mcu_bus_pkg::data_t gpio_meta_q;
  mcu_bus_pkg::data_t gpio_in_q;
  mcu_bus_pkg::data_t rdata_q;
  mcu_bus_pkg::data_t read_word;
  logic req;
  logic ack_q;

  assign offset = bus.adr[3:2];
  assign req = bus.cyc && bus.stb && !ack_q;

  // pins are asynchronous to the bus clock
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      gpio_meta_q <= '0;
      gpio_in_q <= '0;
    end else begin
      gpio_meta_q <= gpio_i;
      gpio_in_q <= gpio_meta_q;
    end
  end

  always_comb begin
    case (offset)
      mcu_addr_pkg::GPIO_OUT: read_word = gpio_o;
      mcu_addr_pkg::GPIO_EN:  read_word = gpio_en_o;
      mcu_addr_pkg::GPIO_IN:  read_word = gpio_in_q;
      default:                read_word = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ack_q <= 1'b0;
      rdata_q <= '0;
      gpio_o <= '0;
      gpio_en_o <= '0;
    end else begin
      ack_q <= req;
      if (req) begin
        rdata_q <= read_word;
        if (bus.we && offset == mcu_addr_pkg::GPIO_OUT) begin
          gpio_o <= mcu_bus_pkg::merge_bytes(gpio_o, bus.dat_w, bus.sel);
        end
        if (bus.we && offset == mcu_addr_pkg::GPIO_EN) begin
          gpio_en_o <= mcu_bus_pkg::merge_bytes(gpio_en_o, bus.dat_w, bus.sel);
        end
      end
    end
  end

  assign bus.ack = ack_q;
  assign bus.dat_r = rdata_q;
  assign bus.err = 1'b0;

  a_rdata_known: assert property (@(posedge clk_i) disable iff (reset_i)
    bus.ack |-> !$isunknown(bus.dat_r));

endmodule

`default_nettype wire

// ==== verilog/ao_peripheral_subsystem.sv ====
// Always-on peripheral registers
// scratch word, boot select strap readback and program exit value
`default_nettype none

module ao_peripheral_subsystem (
  input  logic               clk_i,
  input  logic               reset_i,
  wb_bus_if.slave            bus,
  input  logic               boot_select_i,
  output mcu_bus_pkg::data_t exit_value_o,
  output logic               exit_valid_o
);

  mcu_addr_pkg::reg_off_t offset;
  mcu_bus_pkg::data_t scratch_q;
  mcu_bus_pkg::data_t rdata_q;
  mcu_bus_pkg::data_t read_word;
  logic req;
  logic wr_req;
  logic ack_q;

  assign offset = bus.adr[3:2];
  assign req = bus.cyc && bus.stb && !ack_q;
  assign wr_req = req && bus.we;

  always_comb begin
    case (offset)
      mcu_addr_pkg::AO_SCRATCH:  read_word = scratch_q;
      mcu_addr_pkg::AO_BOOT_SEL: read_word = {{(mcu_bus_pkg::DATA_W-1){1'b0}}, boot_select_i};
      mcu_addr_pkg::AO_EXIT:     read_word = exit_value_o;
      default:                   read_word = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ack_q <= 1'b0;
      rdata_q <= '0;
      scratch_q <= '0;
      exit_value_o <= '0;
      exit_valid_o <= 1'b0;
    end else begin
      ack_q <= req;
      if (req) begin
        rdata_q <= read_word;
      end
      if (wr_req) begin
        // boot select and the spare offset ignore writes
        case (offset)
          mcu_addr_pkg::AO_SCRATCH: begin
            scratch_q <= mcu_bus_pkg::merge_bytes(scratch_q, bus.dat_w, bus.sel);
          end
          mcu_addr_pkg::AO_EXIT: begin
            exit_value_o <= mcu_bus_pkg::merge_bytes(exit_value_o, bus.dat_w, bus.sel);
            exit_valid_o <= 1'b1;
          end
          default: ;
        endcase
      end
    end
  end

  assign bus.ack = ack_q;
  assign bus.dat_r = rdata_q;
  assign bus.err = 1'b0;

  a_exit_valid_on_write: assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(exit_valid_o) |-> $past(wr_req && offset == mcu_addr_pkg::AO_EXIT));

endmodule

`default_nettype wire

// ==== verilog/memory_subsystem.sv ====
// RAM memory subsystem
// two banks of words with byte-select writes and a one-cycle ack
`default_nettype none

module memory_subsystem (
  input logic     clk_i,
  input logic     reset_i,
  wb_bus_if.slave bus
);

  mcu_bus_pkg::data_t mem [2][mcu_addr_pkg::RAM_BANK_WORDS];

  logic bank;
  logic [$clog2(mcu_addr_pkg::RAM_BANK_WORDS)-1:0] word_idx;
  logic req;
  logic ack_q;
  mcu_bus_pkg::data_t rdata_q;

  // top RAM address bit picks the bank, the bits below it the word
  assign bank = bus.adr[$clog2(mcu_addr_pkg::RAM_BYTES)-1];
  assign word_idx = bus.adr[$clog2(mcu_addr_pkg::RAM_BYTES)-2:2];

  // no second ack while the first is still out
  assign req = bus.cyc && bus.stb && !ack_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req) begin
      if (bus.we) begin
        mem[bank][word_idx] <= mcu_bus_pkg::merge_bytes(mem[bank][word_idx],
                                                        bus.dat_w, bus.sel);
      end
      // read returns the word as stored before this cycle
      rdata_q <= mem[bank][word_idx];
    end
  end

  assign bus.ack = ack_q;
  assign bus.dat_r = rdata_q;
  assign bus.err = 1'b0;

  a_ack_after_cyc: assert property (@(posedge clk_i) disable iff (reset_i)
    ack_q |-> $past(bus.cyc));

endmodule

`default_nettype wire

// ==== verilog/system_bus.sv ====
// System bus for the single Wishbone master
// decodes the region, steers stb, muxes responses, errors on unmapped space
`default_nettype none

module system_bus (
  input logic      clk_i,
  input logic      reset_i,
  wb_bus_if.slave  host,
  wb_bus_if.master ram_o,
  wb_bus_if.master ao_o,
  wb_bus_if.master periph_o
);

  mcu_addr_pkg::region_t region;
  logic sel_ram;
  logic sel_ao;
  logic sel_periph;
  logic unmapped;
  logic err_q;

  assign region = host.adr[31:28];
  assign sel_ram = (region == mcu_addr_pkg::REGION_RAM);
  assign sel_ao = (region == mcu_addr_pkg::REGION_AO);
  assign sel_periph = (region == mcu_addr_pkg::REGION_PERIPH);
  assign unmapped = !(sel_ram || sel_ao || sel_periph);

  // only stb is steered, everything else fans out
  assign ram_o.cyc = host.cyc;
  assign ram_o.stb = host.stb && sel_ram;
  assign ram_o.we = host.we;
  assign ram_o.adr = host.adr;
  assign ram_o.dat_w = host.dat_w;
  assign ram_o.sel = host.sel;

  assign ao_o.cyc = host.cyc;
  assign ao_o.stb = host.stb && sel_ao;
  assign ao_o.we = host.we;
  assign ao_o.adr = host.adr;
  assign ao_o.dat_w = host.dat_w;
  assign ao_o.sel = host.sel;

  assign periph_o.cyc = host.cyc;
  assign periph_o.stb = host.stb && sel_periph;
  assign periph_o.we = host.we;
  assign periph_o.adr = host.adr;
  assign periph_o.dat_w = host.dat_w;
  assign periph_o.sel = host.sel;

  // address is held until the response, so the live decode picks it
  always_comb begin
    host.dat_r = '0;
    host.ack = 1'b0;
    host.err = err_q;
    if (sel_ram) begin
      host.dat_r = ram_o.dat_r;
      host.ack = ram_o.ack;
      host.err = err_q || ram_o.err;
    end else if (sel_ao) begin
      host.dat_r = ao_o.dat_r;
      host.ack = ao_o.ack;
      host.err = err_q || ao_o.err;
    end else if (sel_periph) begin
      host.dat_r = periph_o.dat_r;
      host.ack = periph_o.ack;
      host.err = err_q || periph_o.err;
    end
  end

  // one-cycle error pulse for unmapped regions
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= host.cyc && host.stb && unmapped && !err_q;
    end
  end

  a_ack_err_exclusive: assert property (@(posedge clk_i) disable iff (reset_i)
    !(err_q && (ram_o.ack || ao_o.ack || periph_o.ack)));

endmodule

`default_nettype wire

// ==== verilog/wb_bus_if.sv ====
// Wishbone classic bus between fabric blocks
`default_nettype none

interface wb_bus_if;

  logic               cyc;
  logic               stb;
  logic               we;
  mcu_bus_pkg::addr_t adr;
  mcu_bus_pkg::data_t dat_w;
  mcu_bus_pkg::sel_t  sel;
  mcu_bus_pkg::data_t dat_r;
  logic               ack;
  logic               err;

  modport master(
    output cyc, stb, we, adr, dat_w, sel,
    input dat_r, ack, err
  );

  modport slave(
    input cyc, stb, we, adr, dat_w, sel,
    output dat_r, ack, err
  );

endinterface

`default_nettype wire

// ==== verilog/mcu_addr_pkg.sv ====
// Address map of the mini MCU
// region codes, register offsets and RAM geometry
`default_nettype none

package mcu_addr_pkg;

  // region code sits in address bits 31:28
  typedef logic [3:0] region_t;
  // register offset sits in address bits 3:2
  typedef logic [1:0] reg_off_t;

  localparam region_t REGION_RAM = 4'd0;
  localparam region_t REGION_AO = 4'd2;
  localparam region_t REGION_PERIPH = 4'd3;

  // two banks, bank chosen by address bit 11
  localparam int RAM_BYTES = 4096;
  localparam int RAM_BANK_WORDS = 512;

  // always-on registers
  localparam reg_off_t AO_SCRATCH = 2'd0;
  localparam reg_off_t AO_BOOT_SEL = 2'd1;
  localparam reg_off_t AO_EXIT = 2'd2;

  // gpio registers
  localparam reg_off_t GPIO_OUT = 2'd0;
  localparam reg_off_t GPIO_EN = 2'd1;
  localparam reg_off_t GPIO_IN = 2'd2;

endpackage

`default_nettype wire

// ==== verilog/mcu_bus_pkg.sv ====
// Wishbone bus definitions for the mini MCU fabric
// widths, vector types and byte-select merging
`default_nettype none

package mcu_bus_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int SEL_W = DATA_W / 8;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [SEL_W-1:0] sel_t;

  // apply a write under a byte-select mask
  function automatic data_t merge_bytes(data_t old_word, data_t new_word, sel_t sel);
    data_t merged;
    merged = old_word;
    for (int i = 0; i < SEL_W; i++) begin
      if (sel[i]) merged[8*i+:8] = new_word[8*i+:8];
    end
    return merged;
  endfunction

endpackage

`default_nettype wire
